// ==== logic/clk_synth_params.svh ====
`ifndef CLK_SYNTH_PARAMS_SVH
`define CLK_SYNTH_PARAMS_SVH

//****************************************
// widths and counts
//****************************************
`define CS_WORD_W           32  // one synthesizer word
`define CS_NUM_WORDS        26  // data words per programming pass
`define CS_IDX_W            5   // send index / host address width
`define CS_CTRL_ADDR        26  // host address of the control word

//****************************************
// cycle lengths, all in slow_clk cycles
//****************************************
`define CS_POWERUP_CYCLES   64  // kept short here, real parts want >3 ms
`define CS_DEFAULTS_CYCLES  32
`define CS_SYNC_LOW_CYCLES  16

//****************************************
// default words in send order
//****************************************
`define CS_DEF_WORD00 32'h0002_0000  // R0 with RESET set, sent first
`define CS_DEF_WORD01 32'h0014_0320  // R0
`define CS_DEF_WORD02 32'h0014_0321  // R1
`define CS_DEF_WORD03 32'h0014_0322  // R2
`define CS_DEF_WORD04 32'h8014_0323  // R3
`define CS_DEF_WORD05 32'h0014_0324  // R4
`define CS_DEF_WORD06 32'h0014_0325  // R5
`define CS_DEF_WORD07 32'h1111_0006  // R6
`define CS_DEF_WORD08 32'h1111_0007  // R7
`define CS_DEF_WORD09 32'h0111_0008  // R8
`define CS_DEF_WORD10 32'h5555_5549  // R9
`define CS_DEF_WORD11 32'h9102_410A  // R10
`define CS_DEF_WORD12 32'h0401_100B  // R11
`define CS_DEF_WORD13 32'h1B0C_006C  // R12
`define CS_DEF_WORD14 32'h2302_886D  // R13
`define CS_DEF_WORD15 32'h0200_000E  // R14
`define CS_DEF_WORD16 32'h8000_800F  // R15
`define CS_DEF_WORD17 32'hC155_0410  // R16
`define CS_DEF_WORD18 32'h0000_0058  // R24
`define CS_DEF_WORD19 32'h0280_0099  // R25
`define CS_DEF_WORD20 32'hAFA8_001A  // R26
`define CS_DEF_WORD21 32'h1000_003B  // R27
`define CS_DEF_WORD22 32'h0020_007C  // R28
`define CS_DEF_WORD23 32'h0180_033D  // R29
`define CS_DEF_WORD24 32'h0200_033E  // R30
`define CS_DEF_WORD25 32'h0000_001F  // R31, readback mux and uWire lock

`endif

// ==== logic/clk_synth_pkg.sv ====
`default_nettype none

package clk_synth_pkg;

    // power-up sequencer, runs once per resetS
    typedef enum logic [1:0] {
        ST_WAIT,      // power-up wait
        ST_DEFAULTS,  // force bank to defaults
        ST_KICK,      // set control bit 0
        ST_DONE
    } startup_state_t;

    // word writer, one pass over the bank
    typedef enum logic [2:0] {
        WR_IDLE,
        WR_FETCH,      // rd_idx presented, word registered by bank
        WR_LOAD,       // hold shift_start until busy
        WR_SHIFT,      // wait for busy to drop
        WR_NEXT,
        WR_SYNC_LOW,
        WR_SYNC_HIGH
    } writer_state_t;

    // serial shifter
    typedef enum logic [1:0] {
        SH_IDLE,
        SH_LOAD,
        SH_SHIFTING
    } shift_state_t;

endpackage

`default_nettype wire

// ==== logic/lmk_reg_pkg.sv ====
`default_nettype none

`include "clk_synth_params.svh"

package lmk_reg_pkg;

    //****************************************
    // register map types
    //****************************************

    // full uWire word, data plus register address in the low bits
    typedef logic [`CS_WORD_W-1:0] synth_word_t;

    // position of a word in the send order, 0 to 25
    typedef logic [`CS_IDX_W-1:0] word_idx_t;

    // host address: 0..25 data, 26 control, rest ignored
    typedef logic [`CS_IDX_W-1:0] host_addr_t;

    // control word bit that starts a pass on its rising edge
    localparam int CTRL_GO_BIT = 0;

endpackage

`default_nettype wire

// ==== logic/clk_synth_startup.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "clk_synth_params.svh"

module clk_synth_startup (
    input  logic slow_clk,
    input  logic resetS,
    output logic load_defaults,  // level, bank forced to defaults
    output logic kick,           // one cycle, sets control bit 0
    output logic startup_done    // level, enables the sync pulse
);
    import clk_synth_pkg::*;

    // one counter shared by the wait and defaults phases
    localparam int CNT_MAX = (`CS_POWERUP_CYCLES > `CS_DEFAULTS_CYCLES) ?
                             `CS_POWERUP_CYCLES : `CS_DEFAULTS_CYCLES;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);

    startup_state_t   state;
    logic [CNT_W-1:0] cnt;

    always_ff @(posedge slow_clk)
    begin
        if (resetS)
        begin
            state <= ST_WAIT;
            cnt   <= '0;
        end
        else
        begin
            case (state)
                ST_WAIT :
                begin
                    if (cnt == CNT_W'(`CS_POWERUP_CYCLES - 1))
                    begin
                        cnt   <= '0;
                        state <= ST_DEFAULTS;
                    end
                    else
                        cnt <= cnt + 1'b1;  // device still powering up
                end
                ST_DEFAULTS :
                begin
                    if (cnt == CNT_W'(`CS_DEFAULTS_CYCLES - 1))
                    begin
                        cnt   <= '0;
                        state <= ST_KICK;
                    end
                    else
                        cnt <= cnt + 1'b1;
                end
                ST_KICK :
                    state <= ST_DONE;  // single cycle
                ST_DONE :
                    state <= ST_DONE;  // parked until next resetS
                default :
                    state <= ST_WAIT;
            endcase
        end
    end

    // outputs decoded straight from state
    assign load_defaults = (state == ST_DEFAULTS);
    assign kick          = (state == ST_KICK);
    assign startup_done  = (state == ST_DONE);

endmodule

`default_nettype wire

// ==== logic/clk_synth_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "clk_synth_params.svh"

module clk_synth_regs (
    input  logic                     slow_clk,
    input  logic                     resetS,
    input  logic                     load_defaults,
    input  logic                     kick,
    input  logic                     wr_en,
    input  lmk_reg_pkg::host_addr_t  wr_addr,
    input  lmk_reg_pkg::synth_word_t wr_data,
    input  lmk_reg_pkg::word_idx_t   rd_idx,
    output lmk_reg_pkg::synth_word_t rd_word,
    output logic                     program_go
);
    import lmk_reg_pkg::*;

    // defaults in send order, index 0 is the device reset word
    localparam synth_word_t DEF_WORDS [`CS_NUM_WORDS] = '{
        `CS_DEF_WORD00, `CS_DEF_WORD01, `CS_DEF_WORD02, `CS_DEF_WORD03,
        `CS_DEF_WORD04, `CS_DEF_WORD05, `CS_DEF_WORD06, `CS_DEF_WORD07,
        `CS_DEF_WORD08, `CS_DEF_WORD09, `CS_DEF_WORD10, `CS_DEF_WORD11,
        `CS_DEF_WORD12, `CS_DEF_WORD13, `CS_DEF_WORD14, `CS_DEF_WORD15,
        `CS_DEF_WORD16, `CS_DEF_WORD17, `CS_DEF_WORD18, `CS_DEF_WORD19,
        `CS_DEF_WORD20, `CS_DEF_WORD21, `CS_DEF_WORD22, `CS_DEF_WORD23,
        `CS_DEF_WORD24, `CS_DEF_WORD25
    };

    synth_word_t bank [`CS_NUM_WORDS];  // data words
    synth_word_t ctrl_word;             // bit 0 starts a pass
    logic        go_q;                  // last value of the go bit

    logic data_wr;
    logic ctrl_wr;

    // host address decode, 27..31 fall through
    assign data_wr = wr_en && (wr_addr < host_addr_t'(`CS_NUM_WORDS));
    assign ctrl_wr = wr_en && (wr_addr == host_addr_t'(`CS_CTRL_ADDR));

    //****************************************
    // word bank
    //****************************************
    always_ff @(posedge slow_clk)
    begin
        if (resetS || load_defaults)
            bank <= DEF_WORDS;       // defaults win over a host write
        else if (data_wr)
            bank[wr_addr] <= wr_data;
    end

    //****************************************
    // control word and go edge
    //****************************************
    always_ff @(posedge slow_clk)
    begin
        if (resetS)
            ctrl_word <= '0;
        else if (kick)
            ctrl_word <= synth_word_t'(1);  // default has go bit set
        else if (ctrl_wr)
            ctrl_word <= wr_data;
    end

    // rising edge only, so the bit has to be cleared before the next pass
    always_ff @(posedge slow_clk)
    begin
        if (resetS)
        begin
            go_q       <= 1'b0;
            program_go <= 1'b0;
        end
        else
        begin
            go_q       <= ctrl_word[CTRL_GO_BIT];
            program_go <= ctrl_word[CTRL_GO_BIT] & ~go_q;
        end
    end

    // registered read, one cycle after rd_idx
    always_ff @(posedge slow_clk)
    begin
        if (rd_idx < word_idx_t'(`CS_NUM_WORDS))
            rd_word <= bank[rd_idx];
        else
            rd_word <= '0;  // writer never gets here
    end

endmodule

`default_nettype wire

// ==== logic/clk_synth_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "clk_synth_params.svh"

module clk_synth_writer (
    input  logic                     slow_clk,
    input  logic                     resetS,
    input  logic                     program_go,
    input  logic                     startup_done,
    input  logic                     busy,
    input  lmk_reg_pkg::synth_word_t rd_word,
    output lmk_reg_pkg::word_idx_t   rd_idx,
    output lmk_reg_pkg::synth_word_t shift_word,
    output logic                     shift_start,
    output logic                     sync
);
    import clk_synth_pkg::*;
    import lmk_reg_pkg::*;

    localparam int SYNC_CNT_W = $clog2(`CS_SYNC_LOW_CYCLES + 1);

    writer_state_t         state;
    word_idx_t             idx;           // word being sent
    logic                  restart_pend;  // go seen, start at 0 after this word
    logic [SYNC_CNT_W-1:0] sync_cnt;

    assign rd_idx = idx;

    //****************************************
    // pass FSM
    //****************************************
    always_ff @(posedge slow_clk)
    begin
        if (resetS)
        begin
            state        <= WR_IDLE;
            idx          <= '0;
            restart_pend <= 1'b0;
            shift_start  <= 1'b0;
            sync         <= 1'b1;
            sync_cnt     <= '0;
        end
        else
        begin
            case (state)
                WR_IDLE :
                begin
                    sync <= 1'b1;
                    if (restart_pend)
                    begin
                        restart_pend <= 1'b0;
                        idx          <= '0;
                        state        <= WR_FETCH;
                    end
                end
                WR_FETCH :
                    state <= WR_LOAD;  // bank registers word at idx
                WR_LOAD :
                begin
                    // hold start until the shifter takes it
                    if (busy)
                    begin
                        shift_start <= 1'b0;
                        state       <= WR_SHIFT;
                    end
                    else
                        shift_start <= 1'b1;
                end
                WR_SHIFT :
                begin
                    if (!busy)
                        state <= WR_NEXT;  // word done, dlen back high
                end
                WR_NEXT :
                begin
                    if (restart_pend)
                    begin
                        restart_pend <= 1'b0;
                        idx          <= '0;
                        state        <= WR_FETCH;
                    end
                    else if (idx == word_idx_t'(`CS_NUM_WORDS - 1))
                    begin
                        idx <= '0;
                        if (startup_done)
                        begin
                            sync     <= 1'b0;  // pass complete
                            sync_cnt <= '0;
                            state    <= WR_SYNC_LOW;
                        end
                        else
                            state <= WR_IDLE;
                    end
                    else
                    begin
                        idx   <= idx + 1'b1;
                        state <= WR_FETCH;
                    end
                end
                WR_SYNC_LOW :
                begin
                    if (sync_cnt == SYNC_CNT_W'(`CS_SYNC_LOW_CYCLES - 1))
                    begin
                        sync  <= 1'b1;
                        state <= WR_SYNC_HIGH;
                    end
                    else
                        sync_cnt <= sync_cnt + 1'b1;
                end
                WR_SYNC_HIGH :
                    state <= WR_IDLE;  // one settle cycle
                default :
                    state <= WR_IDLE;
            endcase

            // go can land in any state, remembered until consumed
            if (program_go)
                restart_pend <= 1'b1;
        end
    end

    // word handed to the shifter, stable while shift_start is high
    always_ff @(posedge slow_clk)
    begin
        if (state == WR_LOAD)
            shift_word <= rd_word;
    end

endmodule

`default_nettype wire

// ==== logic/clk_synth_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "clk_synth_params.svh"

module clk_synth_shifter (
    input  logic                     slow_clk,
    input  logic                     resetS,
    input  logic                     shift_start,
    input  lmk_reg_pkg::synth_word_t shift_word,
    output logic                     dclk,
    output logic                     ddat,
    output logic                     dlen,
    output logic                     busy
);
    import clk_synth_pkg::*;
    import lmk_reg_pkg::*;

    localparam int BIT_CNT_W = $clog2(`CS_WORD_W);

    shift_state_t         state;
    synth_word_t          sreg;     // MSB on the wire
    logic [BIT_CNT_W-1:0] bit_cnt;

    // device samples on dclk rise, mid-bit
    assign dclk = ~slow_clk;
    assign ddat = sreg[`CS_WORD_W-1];

    always_ff @(posedge slow_clk)
    begin
        if (resetS)
        begin
            state   <= SH_IDLE;
            busy    <= 1'b0;
            dlen    <= 1'b1;
            bit_cnt <= '0;
        end
        else
        begin
            case (state)
                SH_IDLE :
                begin
                    if (shift_start)
                    begin
                        busy  <= 1'b1;
                        state <= SH_LOAD;
                    end
                end
                SH_LOAD :
                begin
                    bit_cnt <= '0;
                    dlen    <= 1'b0;  // first bit goes out with this
                    state   <= SH_SHIFTING;
                end
                SH_SHIFTING :
                begin
                    if (bit_cnt == BIT_CNT_W'(`CS_WORD_W - 1))
                    begin
                        dlen  <= 1'b1;  // latch word in device
                        busy  <= 1'b0;
                        state <= SH_IDLE;
                    end
                    else
                        bit_cnt <= bit_cnt + 1'b1;
                end
                default :
                    state <= SH_IDLE;
            endcase
        end
    end

    // data path, MSB first
    always_ff @(posedge slow_clk)
    begin
        if (state == SH_LOAD)
            sreg <= shift_word;
        else if (state == SH_SHIFTING)
            sreg <= {sreg[`CS_WORD_W-2:0], 1'b0};
    end

endmodule

`default_nettype wire

// ==== logic/clk_synth_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_synth_top (
    input  logic                     slow_clk,
    input  logic                     resetS,
    input  logic                     wr_en,
    input  lmk_reg_pkg::host_addr_t  wr_addr,
    input  lmk_reg_pkg::synth_word_t wr_data,
    output logic                     dclk,
    output logic                     ddat,
    output logic                     dlen,
    output logic                     sync
);

    //****************************************
    // internal nets
    //****************************************
    logic                     load_defaults;
    logic                     kick;
    logic                     startup_done;
    logic                     program_go;
    lmk_reg_pkg::word_idx_t   rd_idx;
    lmk_reg_pkg::synth_word_t rd_word;
    lmk_reg_pkg::synth_word_t shift_word;
    logic                     shift_start;
    logic                     busy;

    // power-up sequencer
    clk_synth_startup u_startup (
        .slow_clk      (slow_clk),
        .resetS        (resetS),
        .load_defaults (load_defaults),
        .kick          (kick),
        .startup_done  (startup_done)
    );

    // word bank and control word, beside the writer it steers
    clk_synth_regs u_regs (
        .slow_clk      (slow_clk),
        .resetS        (resetS),
        .load_defaults (load_defaults),
        .kick          (kick),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .rd_idx        (rd_idx),
        .rd_word       (rd_word),
        .program_go    (program_go)
    );

    clk_synth_writer u_writer (
        .slow_clk     (slow_clk),
        .resetS       (resetS),
        .program_go   (program_go),
        .startup_done (startup_done),
        .busy         (busy),
        .rd_word      (rd_word),
        .rd_idx       (rd_idx),
        .shift_word   (shift_word),
        .shift_start  (shift_start),
        .sync         (sync)
    );

    // uWire pins
    clk_synth_shifter u_shifter (
        .slow_clk    (slow_clk),
        .resetS      (resetS),
        .shift_start (shift_start),
        .shift_word  (shift_word),
        .dclk        (dclk),
        .ddat        (ddat),
        .dlen        (dlen),
        .busy        (busy)
    );

endmodule

`default_nettype wire

// ==== test/clk_synth_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_synth_sva (
    input logic slow_clk,
    input logic resetS,
    input logic dlen,
    input logic sync
);

    // failed assertions so far, watched by the testbench
    int unsigned fail_count = 0;

    //****************************************
    // uWire and sync rules
    //****************************************

    // one word per dlen low window, 32 clocks
    property dlen_low_run;
        @(posedge slow_clk) disable iff (resetS)
            $fell(dlen) |=> (!dlen) [*31] ##1 dlen;
    endproperty

    // sync pulse only between words
    property sync_dlen_apart;
        @(posedge slow_clk) disable iff (resetS)
            !(!sync && !dlen);
    endproperty

    property idle_after_reset;
        @(posedge slow_clk) resetS |=> (dlen && sync);
    endproperty

    a_dlen_low_run : assert property (dlen_low_run)
        else
        begin
            $error("dlen low window is not 32 cycles");
            fail_count++;
        end
    a_sync_dlen_apart : assert property (sync_dlen_apart)
        else
        begin
            $error("sync and dlen low together");
            fail_count++;
        end
    a_idle_after_reset : assert property (idle_after_reset)
        else
        begin
            $error("dlen or sync not high after resetS");
            fail_count++;
        end

endmodule

`default_nettype wire

// ==== test/clk_synth_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "clk_synth_params.svh"

module clk_synth_tb;
    import lmk_reg_pkg::*;

    localparam int PASS_TIMEOUT = 6000;  // cycles, covers startup plus one pass
    localparam int SYNC_TIMEOUT = 100;
    localparam int QUIET_CYCLES = 200;   // no dlen activity expected
    localparam int IDLE_CYCLES  = 40;
    localparam int SEED         = 82425;

    localparam synth_word_t DEFAULTS [`CS_NUM_WORDS] = '{
        `CS_DEF_WORD00, `CS_DEF_WORD01, `CS_DEF_WORD02, `CS_DEF_WORD03,
        `CS_DEF_WORD04, `CS_DEF_WORD05, `CS_DEF_WORD06, `CS_DEF_WORD07,
        `CS_DEF_WORD08, `CS_DEF_WORD09, `CS_DEF_WORD10, `CS_DEF_WORD11,
        `CS_DEF_WORD12, `CS_DEF_WORD13, `CS_DEF_WORD14, `CS_DEF_WORD15,
        `CS_DEF_WORD16, `CS_DEF_WORD17, `CS_DEF_WORD18, `CS_DEF_WORD19,
        `CS_DEF_WORD20, `CS_DEF_WORD21, `CS_DEF_WORD22, `CS_DEF_WORD23,
        `CS_DEF_WORD24, `CS_DEF_WORD25
    };

    logic        slow_clk;
    logic        resetS;
    logic        wr_en;
    host_addr_t  wr_addr;
    synth_word_t wr_data;
    logic        dclk;
    logic        ddat;
    logic        dlen;
    logic        sync;

    synth_word_t captured [$];                 // words seen on the wire
    synth_word_t expected [`CS_NUM_WORDS];     // next pass contents
    int          error_count;
    int          passes_checked;

    clk_synth_top dut (
        .slow_clk (slow_clk),
        .resetS   (resetS),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .dclk     (dclk),
        .ddat     (ddat),
        .dlen     (dlen),
        .sync     (sync)
    );

    bind clk_synth_top clk_synth_sva u_sva (
        .slow_clk (slow_clk),
        .resetS   (resetS),
        .dlen     (dlen),
        .sync     (sync)
    );

    // starts high so the first edge is a fall
    initial
    begin
        slow_clk = 1'b1;
        forever #10 slow_clk = ~slow_clk;
    end

    //****************************************
    // helpers
    //****************************************
    task automatic stop_with_failure(input string msg);
        error_count++;
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic load_default_expect();
        expected = DEFAULTS;
    endtask

    // uWire receiver, device side view
    task automatic capture_serial();
        synth_word_t sh;
        int          nbits;
        sh    = '0;
        nbits = 0;
        forever
        begin
            @(posedge dclk);
            // dclk is slow_clk inverted, so it rises mid-bit
            assert (slow_clk === 1'b0)
                else stop_with_failure($sformatf(
                    "[FAIL] dclk rise: slow_clk got 0x%0h expected 0x0", slow_clk));
            if (resetS)
                nbits = 0;  // partial word dropped
            else if (!dlen)
            begin
                sh    = {sh[`CS_WORD_W-2:0], ddat};  // MSB first
                nbits = nbits + 1;
            end
            else if (nbits != 0)
            begin
                // dlen just rose, word latched
                assert (nbits == `CS_WORD_W)
                    else stop_with_failure($sformatf(
                        "[FAIL] dlen low bits: got 0x%0h expected 0x%0h", nbits, `CS_WORD_W));
                captured.push_back(sh);
                nbits = 0;
            end
        end
    endtask

    task automatic host_write(input host_addr_t addr, input synth_word_t data);
        int gap;
        gap = $urandom_range(3, 0);  // idle gap after the write
        @(negedge slow_clk);
        wr_en   = 1'b1;
        wr_addr = addr;
        wr_data = data;
        @(negedge slow_clk);
        wr_en   = 1'b0;
        repeat (gap) @(negedge slow_clk);
    endtask

    task automatic apply_reset(input int delay);
        repeat (delay) @(negedge slow_clk);
        if (delay > 0)
            assert (captured.size() > 0 && captured.size() < `CS_NUM_WORDS)
                else stop_with_failure("reset did not land inside a programming pass");
        @(negedge slow_clk);
        resetS = 1'b1;
        repeat (5) @(negedge slow_clk);
        resetS = 1'b0;
        @(negedge slow_clk);
        captured.delete();
        load_default_expect();  // bank back to defaults
    endtask

    // end of pass is sync going low
    task automatic check_pass();
        int cycles;
        int low_cycles;
        cycles = 0;
        while (sync !== 1'b0 && cycles < PASS_TIMEOUT)
        begin
            @(negedge slow_clk);
            cycles++;
        end
        assert (sync === 1'b0)
            else stop_with_failure("timed out waiting for sync low after a pass");
        low_cycles = 0;
        while (sync === 1'b0 && low_cycles < SYNC_TIMEOUT)
        begin
            @(negedge slow_clk);
            low_cycles++;
        end
        assert (low_cycles == `CS_SYNC_LOW_CYCLES)
            else stop_with_failure($sformatf("[FAIL] sync low cycles: got 0x%0h expected 0x%0h",
                low_cycles, `CS_SYNC_LOW_CYCLES));
        assert (captured.size() == `CS_NUM_WORDS)
            else stop_with_failure($sformatf("[FAIL] dlen word count: got 0x%0h expected 0x%0h",
                captured.size(), `CS_NUM_WORDS));
        for (int i = 0; i < `CS_NUM_WORDS; i++)
            assert (captured[i] === expected[i])
                else stop_with_failure($sformatf(
                    "[FAIL] ddat word %0d: got 0x%08h expected 0x%08h",
                    i, captured[i], expected[i]));
        // idle after the pass, sync back high and held
        repeat (IDLE_CYCLES)
        begin
            @(negedge slow_clk);
            assert (sync === 1'b1 && dlen === 1'b1)
                else stop_with_failure($sformatf(
                    "[FAIL] sync/dlen while idle: got 0x%0h/0x%0h expected 0x1/0x1", sync, dlen));
        end
        captured.delete();
        passes_checked++;
    endtask

    task automatic check_quiet();
        repeat (QUIET_CYCLES)
        begin
            @(negedge slow_clk);
            assert (dlen === 1'b1)
                else stop_with_failure($sformatf(
                    "[FAIL] dlen with no trigger: got 0x%0h expected 0x1", dlen));
        end
        assert (captured.size() == 0)
            else stop_with_failure("words were sent although no pass was triggered");
    endtask

    initial
    begin
        capture_serial();
    end

    // bound checker failure count
    always @(dut.u_sva.fail_count)
    begin
        assert (dut.u_sva.fail_count == 0)
            else stop_with_failure("a concurrent assertion in clk_synth_sva failed");
    end

    //****************************************
    // command stream
    //****************************************
    initial
    begin : main
        int          fd;
        int          n;
        int          a;
        string       line;
        string       cmd;
        synth_word_t d;
        error_count    = 0;
        passes_checked = 0;
        resetS         = 1'b1;
        wr_en          = 1'b0;
        wr_addr        = '0;
        wr_data        = '0;
        void'($urandom(SEED));
        load_default_expect();
        apply_reset(0);
        fd = $fopen("test/clk_synth_tests.txt", "r");
        assert (fd != 0)
            else stop_with_failure("cannot open test/clk_synth_tests.txt");
        while ($fgets(line, fd) != 0)
        begin
            n = $sscanf(line, "%s", cmd);
            if (n < 1 || cmd.substr(0, 0) == "#")
                continue;  // blank or comment
            a = 0;
            d = '0;
            case (cmd)
                "W" :
                begin
                    n = $sscanf(line, "%s %d %h", cmd, a, d);
                    assert (n == 3) else stop_with_failure("malformed W line in test file");
                    host_write(host_addr_t'(a), d);
                end
                "E" :
                begin
                    n = $sscanf(line, "%s %d %h", cmd, a, d);
                    assert (n == 3 && a < `CS_NUM_WORDS)
                        else stop_with_failure("malformed E line in test file");
                    expected[a] = d;
                end
                "P" :
                begin
                    n = $sscanf(line, "%s %d", cmd, a);
                    if (a != 0)
                        check_pass();
                    else
                        check_quiet();
                end
                "R" :
                begin
                    n = $sscanf(line, "%s %d", cmd, a);
                    apply_reset(a);
                end
                default :
                    stop_with_failure($sformatf("unknown command %s in test file", cmd));
            endcase
        end
        $fclose(fd);
        assert (passes_checked > 0)
            else stop_with_failure("no programming pass was checked");
        if (error_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/clk_synth_tests.txt ====
# columns: cmd arg1 arg2
# W addr(dec) data(hex): host write, addr 26 is the control word
# E idx(dec) word(hex): expected word at that send index in later passes
# P 1: wait for a pass and check it; P 0: expect no pass
# R n: wait n cycles, then pulse resetS
P 1
W 26 00000001
P 0
W 27 deadbeef
W 29 0000001f
W 31 12345678
P 0
W 3 00140ab2
W 10 5555aa49
W 25 0000041f
E 3 00140ab2
E 10 5555aa49
E 25 0000041f
W 26 00000000
W 26 00000001
P 1
W 0 00000000
W 30 ffffffff
E 0 00000000
W 26 00000000
W 26 00000001
P 1
# reset lands mid pass, defaults come back
W 12 ffff006c
W 26 00000000
W 26 00000001
R 300
P 1

// ==== vlog.f ====
+incdir+logic
logic/clk_synth_pkg.sv
logic/lmk_reg_pkg.sv
logic/clk_synth_startup.sv
logic/clk_synth_regs.sv
logic/clk_synth_writer.sv
logic/clk_synth_shifter.sv
logic/clk_synth_top.sv
test/clk_synth_sva.sv
test/clk_synth_tb.sv

// ==== Bender.yml ====
package:
  name: clk_synth

sources:
  - include_dirs:
      - logic
    files:
      - logic/clk_synth_pkg.sv
      - logic/lmk_reg_pkg.sv
      - logic/clk_synth_startup.sv
      - logic/clk_synth_regs.sv
      - logic/clk_synth_writer.sv
      - logic/clk_synth_shifter.sv
      - logic/clk_synth_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/clk_synth_sva.sv
      - test/clk_synth_tb.sv
